// File: exu_ops_pkg.sv
package exu_ops_pkg;

  // 4-bit ALU operation select
  // Codes 12 to 15 are unused and give a zero result
  typedef enum logic [3:0] {
    ALU_IMM  = 4'd0,
    ALU_ADD  = 4'd1,
    ALU_SUB  = 4'd2,
    ALU_AND  = 4'd3,
    ALU_OR   = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SLL  = 4'd6,
    ALU_SRL  = 4'd7,
    ALU_SRA  = 4'd8,
    ALU_SLT  = 4'd9,
    ALU_SLTU = 4'd10,
    ALU_SRC  = 4'd11
  } alu_op_e;

  // Control-flow kind
  typedef enum logic [3:0] {
    BR_NONE = 4'd0,
    BR_BEQ  = 4'd1,
    BR_BNE  = 4'd2,
    BR_BLT  = 4'd3,
    BR_BGE  = 4'd4,
    BR_BLTU = 4'd5,
    BR_BGEU = 4'd6,
    BR_JAL  = 4'd7,
    BR_JALR = 4'd8
  } br_op_e;

endpackage

// File: exu_types_pkg.sv
package exu_types_pkg;

  localparam int XLEN = 32;

  // Bundle handed over by decode
  typedef struct packed {
    logic [XLEN-1:0]       src1;
    // rs2 or the immediate as chosen upstream
    logic [XLEN-1:0]       src2;
    // Raw rs2 for branch compares
    logic [XLEN-1:0]       rs2;
    logic [XLEN-1:0]       imm;
    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       pc_next;
    exu_ops_pkg::alu_op_e  alu_op;
    exu_ops_pkg::br_op_e   br_op;
    logic [4:0]            rd;
    logic                  reg_en;
  } exu_req_t;

  // Bundle handed to the next stage
  typedef struct packed {
    logic [XLEN-1:0] result;
    logic [XLEN-1:0] next_pc;
    logic            taken;
    logic            zero;
    logic [4:0]      rd;
    logic            reg_en;
  } exu_resp_t;

  typedef struct packed {
    logic [XLEN-1:0] result;
    logic            zero;
  } alu_res_t;

  typedef struct packed {
    logic            taken;
    logic            is_jump;
    logic [XLEN-1:0] target;
  } br_res_t;

endpackage

// File: exu_skid.sv
`timescale 1ns/1ps

module exu_skid (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    in_valid_i,
  input  exu_types_pkg::exu_req_t in_req_i,
  output logic                    in_ready_o,
  input  logic                    load_i,
  output logic                    cur_valid_o,
  output exu_types_pkg::exu_req_t cur_req_o
);
  import exu_types_pkg::*;

  exu_req_t buf_q;
  logic     full_q;
  logic     capture;

  // Arriving bundle that commit cannot take this cycle
  assign capture = !full_q && in_valid_i && !load_i;

  assign in_ready_o  = !full_q;
  assign cur_valid_o = full_q || in_valid_i;

  // Buffered bundle goes first
  assign cur_req_o = full_q ? buf_q : in_req_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      full_q <= 1'b0;
    end else if (full_q) begin
      if (load_i) begin
        full_q <= 1'b0;
      end
    end else if (capture) begin
      full_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      buf_q <= in_req_i;
    end
  end

endmodule

// File: exu_alu.sv
`timescale 1ns/1ps

module exu_alu (
  input  exu_types_pkg::exu_req_t cur_req_i,
  output exu_types_pkg::alu_res_t alu_o
);
  import exu_ops_pkg::*;
  import exu_types_pkg::*;

  logic [XLEN-1:0] a;
  logic [XLEN-1:0] b;
  logic [4:0]      shamt;
  logic [XLEN-1:0] res;
  logic            is_arith;

  assign a     = cur_req_i.src1;
  assign b     = cur_req_i.src2;
  assign shamt = b[4:0];

  always_comb begin
    case (cur_req_i.alu_op)
      ALU_IMM:  res = b;
      ALU_ADD:  res = a + b;
      ALU_SUB:  res = a - b;
      ALU_AND:  res = a & b;
      ALU_OR:   res = a | b;
      ALU_XOR:  res = a ^ b;
      ALU_SLL:  res = a << shamt;
      ALU_SRL:  res = a >> shamt;
      ALU_SRA:  res = $unsigned($signed(a) >>> shamt);
      ALU_SLT:  res = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
      ALU_SLTU: res = {{(XLEN-1){1'b0}}, a < b};
      ALU_SRC:  res = a;
      default:  res = '0;
    endcase
  end

  // Zero flag only means something for add and sub
  assign is_arith = (cur_req_i.alu_op == ALU_ADD) || (cur_req_i.alu_op == ALU_SUB);

  assign alu_o.result = res;
  assign alu_o.zero   = is_arith && (res == '0);

endmodule

// File: exu_branch.sv
`timescale 1ns/1ps

module exu_branch (
  input  exu_types_pkg::exu_req_t cur_req_i,
  output exu_types_pkg::br_res_t  br_o
);
  import exu_ops_pkg::*;
  import exu_types_pkg::*;

  logic [XLEN-1:0] a;
  logic [XLEN-1:0] b;
  logic            eq;
  logic            lt_s;
  logic            lt_u;
  logic [XLEN-1:0] jalr_sum;

  assign a    = cur_req_i.src1;
  assign b    = cur_req_i.rs2;
  assign eq   = (a == b);
  assign lt_s = $signed(a) < $signed(b);
  assign lt_u = a < b;

  assign jalr_sum = a + cur_req_i.imm;

  always_comb begin
    br_o.is_jump = 1'b0;
    case (cur_req_i.br_op)
      BR_BEQ:  br_o.taken = eq;
      BR_BNE:  br_o.taken = !eq;
      BR_BLT:  br_o.taken = lt_s;
      BR_BGE:  br_o.taken = !lt_s;
      BR_BLTU: br_o.taken = lt_u;
      BR_BGEU: br_o.taken = !lt_u;
      BR_JAL, BR_JALR: begin
        br_o.taken   = 1'b1;
        br_o.is_jump = 1'b1;
      end
      default: br_o.taken = 1'b0;
    endcase
    // JALR target drops bit 0
    if (cur_req_i.br_op == BR_JALR) begin
      br_o.target = {jalr_sum[XLEN-1:1], 1'b0};
    end else begin
      br_o.target = cur_req_i.pc + cur_req_i.imm;
    end
  end

endmodule

// File: exu_commit.sv
`timescale 1ns/1ps

module exu_commit (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     cur_valid_i,
  input  exu_types_pkg::exu_req_t  cur_req_i,
  input  exu_types_pkg::alu_res_t  alu_i,
  input  exu_types_pkg::br_res_t   br_i,
  input  logic                     out_ready_i,
  output logic                     load_o,
  output logic                     out_valid_o,
  output exu_types_pkg::exu_resp_t out_resp_o
);
  import exu_types_pkg::*;

  exu_resp_t resp_d;

  // Output register free or emptied at this edge
  assign load_o = cur_valid_i && (!out_valid_o || out_ready_i);

  always_comb begin
    // Jumps write the link address
    resp_d.result  = br_i.is_jump ? cur_req_i.pc_next : alu_i.result;
    resp_d.next_pc = br_i.taken ? br_i.target : cur_req_i.pc_next;
    resp_d.taken   = br_i.taken;
    resp_d.zero    = alu_i.zero;
    resp_d.rd      = cur_req_i.rd;
    resp_d.reg_en  = cur_req_i.reg_en;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid_o <= 1'b0;
    end else if (load_o) begin
      out_valid_o <= 1'b1;
    end else if (out_ready_i) begin
      out_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load_o) begin
      out_resp_o <= resp_d;
    end
  end

endmodule

// File: exu.sv
`timescale 1ns/1ps

module exu (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     in_valid_i,
  input  exu_types_pkg::exu_req_t  in_req_i,
  output logic                     in_ready_o,
  output logic                     out_valid_o,
  output exu_types_pkg::exu_resp_t out_resp_o,
  input  logic                     out_ready_i
);
  import exu_types_pkg::*;

  logic     cur_valid;
  exu_req_t cur_req;
  logic     load;
  alu_res_t alu_res;
  br_res_t  br_res;

  exu_skid skid0 (
    .clk         (clk),
    .rst         (rst),
    .in_valid_i  (in_valid_i),
    .in_req_i    (in_req_i),
    .in_ready_o  (in_ready_o),
    .load_i      (load),
    .cur_valid_o (cur_valid),
    .cur_req_o   (cur_req)
  );

  exu_alu alu0 (
    .cur_req_i (cur_req),
    .alu_o     (alu_res)
  );

  exu_branch br0 (
    .cur_req_i (cur_req),
    .br_o      (br_res)
  );

  exu_commit commit0 (
    .clk         (clk),
    .rst         (rst),
    .cur_valid_i (cur_valid),
    .cur_req_i   (cur_req),
    .alu_i       (alu_res),
    .br_i        (br_res),
    .out_ready_i (out_ready_i),
    .load_o      (load),
    .out_valid_o (out_valid_o),
    .out_resp_o  (out_resp_o)
  );

endmodule

// File: exu_sva.sv
`timescale 1ns/1ps

module exu_sva (
  input logic                     clk,
  input logic                     rst,
  input logic                     in_valid_i,
  input exu_types_pkg::exu_req_t  in_req_i,
  input logic                     in_ready_o,
  input logic                     out_valid_o,
  input exu_types_pkg::exu_resp_t out_resp_o,
  input logic                     out_ready_i
);

  // Upstream holds the bundle while stalled
  in_req_stable: assert property (
    @(posedge clk) disable iff (rst)
    (in_valid_i && !in_ready_o) |=> $stable(in_req_i)
  ) else $error("input bundle changed while stalled");

  out_hold: assert property (
    @(posedge clk) disable iff (rst)
    (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(out_resp_o))
  ) else $error("output changed before the next stage took it");

  reset_clears_valid: assert property (
    @(posedge clk) rst |=> !out_valid_o
  ) else $error("out_valid_o high after reset");

endmodule

bind exu exu_sva sva0 (.*);

// File: exu_tb.sv
`timescale 1ns/1ps

module exu_tb;
  import exu_ops_pkg::*;
  import exu_types_pkg::*;

  localparam int CLK_PERIOD    = 10;
  localparam int TOTAL_BUNDLES = 334;
  localparam int MARGIN_CYCLES = 500;
  localparam logic [31:0] EDGE_A [4] = '{32'd0, 32'h8000_0001, 32'hffff_ffff, 32'h7fff_ffff};
  localparam logic [31:0] EDGE_B [4] = '{32'd0, 32'd31, 32'd1, 32'h8000_0000};

  logic      clk;
  logic      rst;
  logic      in_valid;
  exu_req_t  in_req;
  logic      in_ready;
  logic      out_valid;
  exu_resp_t out_resp;
  logic      out_ready;

  integer    seed = 43245;
  int        errors;
  int        checks;
  int        accepted;
  int        cyc = 0;
  logic      check_lat;
  string     test_name;
  exu_resp_t exp_q[$];
  int        acc_cyc_q[$];

  exu dut0 (
    .clk         (clk),
    .rst         (rst),
    .in_valid_i  (in_valid),
    .in_req_i    (in_req),
    .in_ready_o  (in_ready),
    .out_valid_o (out_valid),
    .out_resp_o  (out_resp),
    .out_ready_i (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  function automatic exu_resp_t model(exu_req_t r);
    exu_resp_t   e;
    logic [31:0] a;
    logic [31:0] b;
    logic [4:0]  sh;
    logic [31:0] alu;
    logic [31:0] tgt;
    logic        lt_s;
    logic        lt_u;
    logic        taken;
    logic        jump;
    a = r.src1;
    b = r.src2;
    sh = b[4:0];
    lt_u = a < b;
    // Signs differ, so the negative one is smaller
    lt_s = (a[31] != b[31]) ? a[31] : lt_u;
    case (r.alu_op)
      ALU_IMM:  alu = b;
      ALU_ADD:  alu = a + b;
      ALU_SUB:  alu = a - b;
      ALU_AND:  alu = a & b;
      ALU_OR:   alu = a | b;
      ALU_XOR:  alu = a ^ b;
      ALU_SLL:  alu = a << sh;
      ALU_SRL:  alu = a >> sh;
      ALU_SRA:  alu = (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'd0);
      ALU_SLT:  alu = {31'd0, lt_s};
      ALU_SLTU: alu = {31'd0, lt_u};
      ALU_SRC:  alu = a;
      default:  alu = 32'd0;
    endcase
    // Branch compares against raw rs2
    b = r.rs2;
    lt_u = a < b;
    lt_s = (a[31] != b[31]) ? a[31] : lt_u;
    jump = (r.br_op == BR_JAL) || (r.br_op == BR_JALR);
    case (r.br_op)
      BR_BEQ:  taken = (a == b);
      BR_BNE:  taken = (a != b);
      BR_BLT:  taken = lt_s;
      BR_BGE:  taken = !lt_s;
      BR_BLTU: taken = lt_u;
      BR_BGEU: taken = !lt_u;
      default: taken = jump;
    endcase
    tgt = (r.br_op == BR_JALR) ? ((a + r.imm) & ~32'd1) : (r.pc + r.imm);
    e.result = jump ? r.pc_next : alu;
    e.next_pc = taken ? tgt : r.pc_next;
    e.taken = taken;
    e.zero = ((r.alu_op == ALU_ADD) || (r.alu_op == ALU_SUB)) && (alu == 32'd0);
    e.rd = r.rd;
    e.reg_en = r.reg_en;
    return e;
  endfunction

  function automatic exu_req_t make_req(alu_op_e aop, br_op_e bop, logic [31:0] s1,
                                        logic [31:0] s2, logic [31:0] r2, logic [31:0] imm);
    exu_req_t    r;
    logic [31:0] rnd;
    rnd = $random(seed);
    r.src1 = s1;
    r.src2 = s2;
    r.rs2 = r2;
    r.imm = imm;
    r.pc = {rnd[31:2], 2'b00};
    r.pc_next = r.pc + 32'd4;
    r.alu_op = aop;
    r.br_op = bop;
    rnd = $random(seed);
    r.rd = rnd[4:0];
    r.reg_en = rnd[5];
    return r;
  endfunction

  function automatic exu_req_t rand_req();
    logic [31:0] sel;
    logic [31:0] s1;
    logic [31:0] s2;
    logic [31:0] imm;
    sel = $random(seed);
    s1 = $random(seed);
    s2 = $random(seed);
    imm = $random(seed);
    return make_req(alu_op_e'(sel[3:0]),
                    (sel[7:4] > 4'd8) ? BR_NONE : br_op_e'(sel[7:4]),
                    s1, s2, sel[8] ? s1 : s2, imm);
  endfunction

  // Holds the bundle until the DUT takes it
  task automatic send(exu_req_t r);
    logic done;
    done = 1'b0;
    in_valid = 1'b1;
    in_req = r;
    while (!done) begin
      @(negedge clk);
      if (in_ready) begin
        exp_q.push_back(model(r));
        acc_cyc_q.push_back(cyc);
        accepted++;
        done = 1'b1;
      end
      @(posedge clk);
      #1;
    end
  endtask

  task automatic watch_outputs();
    exu_resp_t exp;
    int        lat;
    forever begin
      @(negedge clk);
      if (!rst && out_valid && out_ready) begin
        checks++;
        assert (exp_q.size() != 0) else begin
          errors++;
          $display("%s: output transfer with nothing outstanding", test_name);
        end
        if (exp_q.size() != 0) begin
          exp = exp_q.pop_front();
          lat = cyc - acc_cyc_q.pop_front();
          assert (out_resp == exp) else begin
            errors++;
            $display("[ERROR] %s: expected %h, got %h", test_name, exp, out_resp);
          end
          if (check_lat) begin
            assert (lat == 1) else begin
              errors++;
              $display("[ERROR] %s: expected latency %0d, got %0d", test_name, 1, lat);
            end
          end
        end
      end
    end
  endtask

  task automatic drain();
    int n;
    n = 0;
    in_valid = 1'b0;
    out_ready = 1'b1;
    while ((exp_q.size() != 0) && (n < 50)) begin
      @(posedge clk);
      #1;
      n++;
    end
    checks++;
    assert (exp_q.size() == 0) else begin
      errors++;
      $display("%s: %0d bundles never came out", test_name, exp_q.size());
      exp_q.delete();
      acc_cyc_q.delete();
    end
  endtask

  task automatic reset_state();
    test_name = "reset_state";
    checks += 2;
    assert (out_valid == 1'b0) else begin
      errors++;
      $display("[ERROR] %s: expected out_valid %b, got %b", test_name, 1'b0, out_valid);
    end
    assert (in_ready == 1'b1) else begin
      errors++;
      $display("[ERROR] %s: expected in_ready %b, got %b", test_name, 1'b1, in_ready);
    end
  endtask

  task automatic alu_ops();
    logic [31:0] s1;
    logic [31:0] s2;
    test_name = "alu_ops";
    out_ready = 1'b1;
    for (int op = 0; op < 16; op++) begin
      for (int k = 0; k < 6; k++) begin
        if (k < 4) begin
          s1 = EDGE_A[k];
          s2 = EDGE_B[k];
        end else begin
          s1 = $random(seed);
          s2 = $random(seed);
        end
        send(make_req(alu_op_e'(op[3:0]), BR_NONE, s1, s2, s2, s2));
      end
    end
    drain();
  endtask

  task automatic branches();
    logic [31:0] p;
    logic [31:0] q;
    logic [31:0] t;
    test_name = "branches";
    out_ready = 1'b1;
    p = 32'hffff_fff0;
    q = 32'd1;
    // Swapped and equal operands give taken and not taken for every condition
    for (int b = 1; b <= 6; b++) begin
      send(make_req(ALU_SUB, br_op_e'(b[3:0]), p, q, q, 32'h0000_0040));
      send(make_req(ALU_SUB, br_op_e'(b[3:0]), q, p, p, 32'hffff_ff80));
      send(make_req(ALU_SUB, br_op_e'(b[3:0]), p, p, p, 32'h0000_0100));
    end
    send(make_req(ALU_ADD, BR_NONE, p, p, p, 32'h0000_0010));
    t = $random(seed);
    send(make_req(ALU_ADD, BR_JAL, t, t, t, {t[31:2], 2'b00}));
    send(make_req(ALU_ADD, BR_JALR, t | 32'd1, t, t, 32'h0000_0020));
    send(make_req(ALU_ADD, BR_JALR, t & ~32'd1, t, t, 32'h0000_0010));
    drain();
  endtask

  task automatic back_to_back();
    test_name = "back_to_back";
    out_ready = 1'b1;
    check_lat = 1'b1;
    for (int i = 0; i < 10; i++) send(rand_req());
    drain();
    check_lat = 1'b0;
  endtask

  task automatic backpressure();
    int acc0;
    test_name = "backpressure";
    out_ready = 1'b0;
    acc0 = accepted;
    fork
      begin
        for (int i = 0; i < 6; i++) send(rand_req());
      end
      begin
        repeat (8) @(posedge clk);
        #1;
        checks += 2;
        assert (accepted - acc0 == 2) else begin
          errors++;
          $display("[ERROR] %s: expected %0d accepted, got %0d", test_name, 2, accepted - acc0);
        end
        assert (in_ready == 1'b0) else begin
          errors++;
          $display("[ERROR] %s: expected in_ready %b, got %b", test_name, 1'b0, in_ready);
        end
        out_ready = 1'b1;
      end
    join
    drain();
  endtask

  task automatic random_traffic();
    logic [31:0] rnd_v;
    logic [31:0] rnd_r;
    logic        done;
    test_name = "random_traffic";
    done = 1'b0;
    fork
      begin
        for (int i = 0; i < 200; i++) begin
          rnd_v = $random(seed);
          if (rnd_v[1:0] == 2'd0) begin
            in_valid = 1'b0;
            @(posedge clk);
            #1;
          end
          send(rand_req());
        end
        done = 1'b1;
      end
      begin
        while (!done) begin
          rnd_r = $random(seed);
          out_ready = rnd_r[0] | rnd_r[1];
          @(posedge clk);
          #1;
        end
      end
    join
    drain();
  endtask

  initial begin
    #((TOTAL_BUNDLES * 20 + MARGIN_CYCLES) * CLK_PERIOD);
    $display("Timeout: the run did not finish in time");
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    rst = 1'b1;
    in_valid = 1'b0;
    in_req = '0;
    out_ready = 1'b0;
    check_lat = 1'b0;
    errors = 0;
    checks = 0;
    accepted = 0;
    test_name = "reset";
    fork
      watch_outputs();
    join_none
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;
    reset_state();
    alu_ops();
    branches();
    back_to_back();
    backpressure();
    random_traffic();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: vlog.f
exu_ops_pkg.sv
exu_types_pkg.sv
exu_skid.sv
exu_alu.sv
exu_branch.sv
exu_commit.sv
exu.sv
exu_sva.sv
exu_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = exu_tb
FILELIST  = vlog.f
PASS_MSG  = ALL TESTS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
